//--- common/vec_alu_cfg.svh
`ifndef VEC_ALU_CFG_SVH
`define VEC_ALU_CFG_SVH

// Full operand and result width
`define VEC_DATA_W      64

// R-type function field
`define VEC_OPCODE_W    6

// Lane width select
`define VEC_WW_W        2

// Issue to result latency in cycles
`define VEC_PIPE_DEPTH  2

`endif

//--- common/vec_alu_pkg.sv
`default_nettype none

`include "vec_alu_cfg.svh"

package vec_alu_pkg;

	// R-type function codes, same encoding as the scalar ALU
	// Gaps 6'b001000, 6'b001001 and 6'b001110 to 6'b010010 were the
	// multiply, divide, modulo and root group
	typedef enum logic [`VEC_OPCODE_W-1:0] {
		VNOP  = 6'b000000,
		VAND  = 6'b000001,
		VOR   = 6'b000010,
		VXOR  = 6'b000011,
		VNOT  = 6'b000100,
		VMOV  = 6'b000101,
		VADD  = 6'b000110,
		VSUB  = 6'b000111,
		VSLL  = 6'b001010,
		VSRL  = 6'b001011,
		VSRA  = 6'b001100,
		VRTTH = 6'b001101
	} vec_op_e;

	// Lane width, ww field encoding
	typedef enum logic [`VEC_WW_W-1:0] {
		W8  = 2'd0,
		W16 = 2'd1,
		W32 = 2'd2,
		W64 = 2'd3
	} lane_width_e;

	// Whole vector, lane 0 in the top bits
	typedef logic [`VEC_DATA_W-1:0] vec_t;

	// Lane payloads
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] half_t;
	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;

endpackage

`default_nettype wire

//--- simd_lanes/simd_lane_alu.sv
`timescale 1ns/1ps
`default_nettype none

module simd_lane_alu #(
	parameter type lane_t = logic [7:0]
) (
	input  vec_alu_pkg::vec_op_e op,
	input  lane_t                a,
	input  lane_t                b,
	output lane_t                y
);
	import vec_alu_pkg::*;

	localparam int LANE_W = $bits(lane_t);
	localparam int HALF_W = LANE_W / 2;
	localparam int SH_W   = $clog2(LANE_W);

	// Shift count from the low bits of this lane of rb
	logic [SH_W-1:0] sh;

	assign sh = b[SH_W-1:0];

	always_comb begin
		case (op)
			VAND:  y = a & b;
			VOR:   y = a | b;
			VXOR:  y = a ^ b;
			VNOT:  y = ~a;
			VMOV:  y = a;
			// Carry out of the lane is dropped
			VADD:  y = a + b;
			VSUB:  y = a - b;
			VSLL:  y = a << sh;
			VSRL:  y = a >> sh;
			// Sign fill from the lane's top bit
			VSRA:  y = lane_t'($signed(a) >>> sh);
			VRTTH: y = {a[HALF_W-1:0], a[LANE_W-1:HALF_W]};
			// VNOP and decoded illegal ops
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- simd_lanes/simd_lane_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_cfg.svh"

module simd_lane_array (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     s1_valid,
	input  vec_alu_pkg::vec_op_e     s1_op,
	input  vec_alu_pkg::lane_width_e s1_width,
	input  vec_alu_pkg::vec_t        s1_ra,
	input  vec_alu_pkg::vec_t        s1_rb,
	input  logic                     s1_illegal,
	output logic                     out_valid,
	output vec_alu_pkg::vec_t        result,
	output logic                     illegal
);
	import vec_alu_pkg::*;

	localparam int B_W = $bits(byte_t);
	localparam int H_W = $bits(half_t);
	localparam int W_W = $bits(word_t);
	localparam int D_W = $bits(dword_t);

	localparam int N_B = `VEC_DATA_W / B_W;
	localparam int N_H = `VEC_DATA_W / H_W;
	localparam int N_W = `VEC_DATA_W / W_W;
	localparam int N_D = `VEC_DATA_W / D_W;

	// One reassembled vector per lane width
	vec_t res_b;
	vec_t res_h;
	vec_t res_w;
	vec_t res_d;
	vec_t res_sel;

	// Lane i sits at the top end, so slices count down from the MSB
	for (genvar i = 0; i < N_B; i++) begin : g_byte
		simd_lane_alu #(.lane_t(byte_t)) u_lane (
			.op (s1_op),
			.a  (s1_ra[`VEC_DATA_W-1-i*B_W -: B_W]),
			.b  (s1_rb[`VEC_DATA_W-1-i*B_W -: B_W]),
			.y  (res_b[`VEC_DATA_W-1-i*B_W -: B_W])
		);
	end

	for (genvar i = 0; i < N_H; i++) begin : g_half
		simd_lane_alu #(.lane_t(half_t)) u_lane (
			.op (s1_op),
			.a  (s1_ra[`VEC_DATA_W-1-i*H_W -: H_W]),
			.b  (s1_rb[`VEC_DATA_W-1-i*H_W -: H_W]),
			.y  (res_h[`VEC_DATA_W-1-i*H_W -: H_W])
		);
	end

	for (genvar i = 0; i < N_W; i++) begin : g_word
		simd_lane_alu #(.lane_t(word_t)) u_lane (
			.op (s1_op),
			.a  (s1_ra[`VEC_DATA_W-1-i*W_W -: W_W]),
			.b  (s1_rb[`VEC_DATA_W-1-i*W_W -: W_W]),
			.y  (res_w[`VEC_DATA_W-1-i*W_W -: W_W])
		);
	end

	for (genvar i = 0; i < N_D; i++) begin : g_dword
		simd_lane_alu #(.lane_t(dword_t)) u_lane (
			.op (s1_op),
			.a  (s1_ra[`VEC_DATA_W-1-i*D_W -: D_W]),
			.b  (s1_rb[`VEC_DATA_W-1-i*D_W -: D_W]),
			.y  (res_d[`VEC_DATA_W-1-i*D_W -: D_W])
		);
	end

	// Pick the group that matches ww
	always_comb begin
		case (s1_width)
			W8:      res_sel = res_b;
			W16:     res_sel = res_h;
			W32:     res_sel = res_w;
			default: res_sel = res_d;
		endcase
	end

	// Stage 2
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			result    <= '0;
			illegal   <= 1'b0;
		end else begin
			out_valid <= s1_valid;
			if (s1_valid) begin
				result  <= res_sel;
				illegal <= s1_illegal;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/vec_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_cfg.svh"

module vec_issue (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  logic [`VEC_OPCODE_W-1:0] r_ins,
	input  logic [`VEC_WW_W-1:0]     ww,
	input  vec_alu_pkg::vec_t        ra,
	input  vec_alu_pkg::vec_t        rb,
	output logic                     s1_valid,
	output vec_alu_pkg::vec_op_e     s1_op,
	output vec_alu_pkg::lane_width_e s1_width,
	output vec_alu_pkg::vec_t        s1_ra,
	output vec_alu_pkg::vec_t        s1_rb,
	output logic                     s1_illegal
);
	import vec_alu_pkg::*;

	vec_op_e dec_op;
	logic    dec_illegal;

	// Function field decode against the supported set
	always_comb begin
		dec_op      = VNOP;
		dec_illegal = 1'b0;
		case (r_ins)
			VNOP, VAND, VOR, VXOR, VNOT, VMOV,
			VADD, VSUB, VSLL, VSRL, VSRA, VRTTH: begin
				dec_op = vec_op_e'(r_ins);
			end
			// Multiply, divide and root codes end up here
			default: begin
				dec_illegal = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid   <= 1'b0;
			s1_illegal <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			if (in_valid) begin
				s1_illegal <= dec_illegal;
			end
		end
	end

	// Stage 1 operand capture
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_op    <= dec_op;
			s1_width <= lane_width_e'(ww);
			s1_ra    <= ra;
			s1_rb    <= rb;
		end
	end

endmodule

`default_nettype wire

//--- rtl/vec_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_cfg.svh"

module vec_alu (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  logic [`VEC_OPCODE_W-1:0] r_ins,
	input  logic [`VEC_WW_W-1:0]     ww,
	input  vec_alu_pkg::vec_t        ra,
	input  vec_alu_pkg::vec_t        rb,
	output logic                     out_valid,
	output vec_alu_pkg::vec_t        result,
	output logic                     illegal
);
	import vec_alu_pkg::*;

	// Stage 1 register outputs
	logic        s1_valid;
	vec_op_e     s1_op;
	lane_width_e s1_width;
	vec_t        s1_ra;
	vec_t        s1_rb;
	logic        s1_illegal;

	vec_issue u_issue (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.r_ins      (r_ins),
		.ww         (ww),
		.ra         (ra),
		.rb         (rb),
		.s1_valid   (s1_valid),
		.s1_op      (s1_op),
		.s1_width   (s1_width),
		.s1_ra      (s1_ra),
		.s1_rb      (s1_rb),
		.s1_illegal (s1_illegal)
	);

	simd_lane_array u_lanes (
		.clk        (clk),
		.rst_n      (rst_n),
		.s1_valid   (s1_valid),
		.s1_op      (s1_op),
		.s1_width   (s1_width),
		.s1_ra      (s1_ra),
		.s1_rb      (s1_rb),
		.s1_illegal (s1_illegal),
		.out_valid  (out_valid),
		.result     (result),
		.illegal    (illegal)
	);

endmodule

`default_nettype wire

//--- dv/vec_alu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_cfg.svh"

module vec_alu_asserts (
	input logic              clk,
	input logic              rst_n,
	input logic              in_valid,
	input logic              out_valid,
	input logic              illegal,
	input vec_alu_pkg::vec_t result
);

	// Fixed pipeline latency
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> ##(`VEC_PIPE_DEPTH) out_valid)
		else $error("out_valid did not follow in_valid after the pipeline depth");

	// Illegal ops leave a zero result
	a_illegal_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && illegal) |-> (result == '0))
		else $error("illegal result is not zero");

	a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(result))
		else $error("result has unknown bits while out_valid is high");

endmodule

bind vec_alu vec_alu_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.illegal   (illegal),
	.result    (result)
);

`default_nettype wire

//--- dv/vec_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_cfg.svh"

module vec_alu_tb;
	import vec_alu_pkg::*;

	localparam int WAIT_LIMIT = 20;

	logic                     clk;
	logic                     rst_n;
	logic                     in_valid;
	logic [`VEC_OPCODE_W-1:0] r_ins;
	logic [`VEC_WW_W-1:0]     ww;
	vec_t                     ra;
	vec_t                     rb;
	logic                     out_valid;
	vec_t                     result;
	logic                     illegal;

	int          err_cnt;
	int          timeout_cnt;
	logic [31:0] lfsr;

	vec_alu vec_alu_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.r_ins     (r_ins),
		.ww        (ww),
		.ra        (ra),
		.rb        (rb),
		.out_valid (out_valid),
		.result    (result),
		.illegal   (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic vec_t rand_vec();
		vec_t v;
		v = '0;
		for (int i = 0; i < `VEC_DATA_W; i++) begin
			v = {v[`VEC_DATA_W-2:0], rand_bit()};
		end
		return v;
	endfunction

	// Kept codes are 0x00 to 0x07 and 0x0A to 0x0D
	function automatic logic legal_code(input logic [5:0] op);
		return (op <= 6'h07) || (op >= 6'h0A && op <= 6'h0D);
	endfunction

	// One lane of width w, operands right aligned
	function automatic vec_t lane_model(input logic [5:0] op, input vec_t a, input vec_t b,
			input int w);
		vec_t mask;
		vec_t r;
		int   sh;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		sh = int'(b[5:0]) & (w - 1);
		case (op)
			VAND:  r = a & b;
			VOR:   r = a | b;
			VXOR:  r = a ^ b;
			VNOT:  r = ~a;
			VMOV:  r = a;
			VADD:  r = a + b;
			VSUB:  r = a - b;
			VSLL:  r = a << sh;
			VSRL:  r = a >> sh;
			VSRA: begin
				r = a >> sh;
				// Sign fill into the vacated top bits
				if (a[w-1])
					r = r | (mask & ~(mask >> sh));
			end
			VRTTH: r = (a >> (w / 2)) | (a << (w / 2));
			default: r = '0;
		endcase
		return r & mask;
	endfunction

	function automatic vec_t vec_model(input logic [5:0] op, input logic [1:0] w_code,
			input vec_t a, input vec_t b);
		int   w;
		int   lo;
		vec_t mask;
		vec_t res;
		w = 8 << w_code;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		res = '0;
		// Lane 0 is the most significant slice
		for (int i = 0; i < 64 / w; i++) begin
			lo = 64 - (i + 1) * w;
			res = res | (lane_model(op, (a >> lo) & mask, (b >> lo) & mask, w) << lo);
		end
		return legal_code(op) ? res : '0;
	endfunction

	task automatic flag_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic issue_and_check(input logic [5:0] op, input logic [1:0] w_code,
			input vec_t a, input vec_t b);
		vec_t exp_res;
		logic exp_ill;
		int   cycles;
		exp_ill = !legal_code(op);
		exp_res = vec_model(op, w_code, a, b);
		@(negedge clk);
		in_valid = 1'b1;
		r_ins = op;
		ww = w_code;
		ra = a;
		rb = b;
		cycles = 0;
		do begin
			@(negedge clk);
			in_valid = 1'b0;
			cycles++;
		end while (!out_valid && cycles < WAIT_LIMIT);
		if (!out_valid) begin
			$display("Timeout: out_valid never rose for opcode %h", op);
			timeout_cnt++;
		end else begin
			if (cycles != `VEC_PIPE_DEPTH)
				flag_error($sformatf("opcode %h latency %0d cycles", op, cycles));
			if (result !== exp_res || illegal !== exp_ill)
				flag_error($sformatf("opcode %h ww %0d got %h ill %b, expected %h ill %b",
					op, w_code, result, illegal, exp_res, exp_ill));
		end
	endtask

	task automatic check_reset();
		if (out_valid !== 1'b0 || illegal !== 1'b0 || result !== '0)
			flag_error($sformatf("after reset out_valid %b illegal %b result %h",
				out_valid, illegal, result));
	endtask

	task automatic bitwise_ops();
		logic [5:0] ops [5];
		ops = '{VAND, VOR, VXOR, VNOT, VMOV};
		for (int i = 0; i < 5; i++) begin
			for (int k = 0; k < 4; k++) begin
				issue_and_check(ops[i], 2'(k), rand_vec(), rand_vec());
			end
		end
	endtask

	task automatic add_sub_wrap();
		vec_t ones_per_lane;
		int   w;
		for (int k = 0; k < 4; k++) begin
			w = 8 << k;
			ones_per_lane = '0;
			for (int i = 0; i < 64 / w; i++)
				ones_per_lane[i * w] = 1'b1;
			// Every lane wraps, nothing may carry into the next lane
			issue_and_check(VADD, 2'(k), '1, ones_per_lane);
			issue_and_check(VSUB, 2'(k), '0, ones_per_lane);
			issue_and_check(VADD, 2'(k), rand_vec(), rand_vec());
			issue_and_check(VSUB, 2'(k), rand_vec(), rand_vec());
		end
	endtask

	task automatic shift_ops();
		for (int k = 0; k < 4; k++) begin
			for (int n = 0; n < 3; n++) begin
				issue_and_check(VSLL, 2'(k), rand_vec(), rand_vec());
				issue_and_check(VSRL, 2'(k), rand_vec(), rand_vec());
				issue_and_check(VSRA, 2'(k), rand_vec(), rand_vec());
			end
		end
	endtask

	task automatic swap_nop_illegal();
		for (int k = 0; k < 4; k++)
			issue_and_check(VRTTH, 2'(k), rand_vec(), rand_vec());
		issue_and_check(VNOP, 2'd2, rand_vec(), rand_vec());
		// Former multiply and root codes, then an unused one
		issue_and_check(6'h08, 2'd0, rand_vec(), rand_vec());
		issue_and_check(6'h12, 2'd3, rand_vec(), rand_vec());
		issue_and_check(6'h3f, 2'd1, rand_vec(), rand_vec());
	endtask

	task automatic back_to_back();
		logic [5:0] ops [6];
		logic [1:0] wws [6];
		vec_t       exp_res [6];
		int         k;
		ops = '{VADD, VSUB, VSLL, VSRA, VRTTH, VXOR};
		wws = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd1, 2'd0};
		for (int j = 0; j < 6 + `VEC_PIPE_DEPTH; j++) begin
			@(negedge clk);
			k = j - `VEC_PIPE_DEPTH;
			if (k >= 0) begin
				if (!out_valid)
					flag_error($sformatf("back to back op %0d missing out_valid", k));
				else if (result !== exp_res[k] || illegal !== 1'b0)
					flag_error($sformatf("back to back op %0d got %h expected %h",
						k, result, exp_res[k]));
			end else if (out_valid) begin
				flag_error("out_valid high before first back to back result");
			end
			if (j < 6) begin
				in_valid = 1'b1;
				r_ins = ops[j];
				ww = wws[j];
				ra = rand_vec();
				rb = rand_vec();
				exp_res[j] = vec_model(ops[j], wws[j], ra, rb);
			end else begin
				in_valid = 1'b0;
			end
		end
	endtask

	initial begin
		err_cnt = 0;
		timeout_cnt = 0;
		lfsr = 32'h3260_2d47;
		rst_n = 1'b0;
		in_valid = 1'b0;
		r_ins = '0;
		ww = '0;
		ra = '0;
		rb = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_reset();
		bitwise_ops();
		add_sub_wrap();
		shift_ops();
		swap_nop_illegal();
		back_to_back();
		$display("Errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/vec_alu_pkg.sv
simd_lanes/simd_lane_alu.sv
simd_lanes/simd_lane_array.sv
rtl/vec_issue.sv
rtl/vec_alu.sv
dv/vec_alu_asserts.sv
dv/vec_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module vec_alu_tb -o Vvec_alu_tb

out=$(./obj_dir/Vvec_alu_tb 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"
